// ==== hw/flashIoPkg.sv ====
package flashIoPkg;

    // storage geometry
    localparam int memDepth = 2048;
    localparam int memAddrBits = 11;
    localparam int memDataBits = 16;

    // memory view of an io word, ctrl flag is 0
    typedef struct packed {
        logic ctrl;
        logic [3:0] reserved;
        logic [memAddrBits-1:0] addr;
        logic [memDataBits-1:0] data;
    } memAccessT;

    // control view of an io word, ctrl flag is 1
    // a count of zero streams nothing
    typedef struct packed {
        logic ctrl;
        logic [3:0] reserved;
        logic [memAddrBits-1:0] startAddr;
        logic [4:0] pad;
        logic [memAddrBits-1:0] count;
    } streamCtrlT;

    // both views share bit 31 as the selector
    typedef union packed {
        memAccessT mem;
        streamCtrlT ctrl;
    } ioWordU;

    // outgoing io port payload from the processor
    typedef struct packed {
        logic responseRequested;
        logic [3:0] destReg;
        ioWordU word;
    } ioOutCmdT;

    typedef enum logic [1:0] {
        memStore,
        memLoad,
        streamStart,
        statusLoad
    } cmdKindT;

    // one flat form of the command after decode
    typedef struct packed {
        cmdKindT kind;
        logic [memAddrBits-1:0] addr;
        logic [memDataBits-1:0] data;
        logic [memAddrBits-1:0] count;
        logic [3:0] destReg;
    } decodedCmdT;

    // incoming io port payload back to the processor
    typedef struct packed {
        logic regResponse;
        logic memResponse;
        logic [3:0] destReg;
        logic [31:0] data;
    } ioResponseT;

    // one word toward the external programmer
    typedef struct packed {
        logic valid;
        logic [memAddrBits-1:0] addr;
        logic [memDataBits-1:0] data;
    } streamOutT;

endpackage

// ==== hw/flashMemory.sv ====
module flashMemory (
    input  logic clk,
    input  logic clkEn,
    input  logic writeEn,
    input  logic [flashIoPkg::memAddrBits-1:0] writeAddr,
    input  logic [flashIoPkg::memDataBits-1:0] writeData,
    input  logic streamReadEn,
    input  logic [flashIoPkg::memAddrBits-1:0] streamAddr,
    input  logic [flashIoPkg::memAddrBits-1:0] cmdAddr,
    output logic [flashIoPkg::memDataBits-1:0] bufferData
);
    import flashIoPkg::*;

    logic [memDataBits-1:0] storage [memDepth];
    logic [memAddrBits-1:0] readAddr;
    logic [memDataBits-1:0] readWord;

    // store lands on the accepting edge
    always_ff @(posedge clk) begin
        if (clkEn && writeEn) begin
            storage[writeAddr] <= writeData;
        end
    end

    // flasher wins the read port while streaming
    // otherwise the address of the command on the bus is read
    assign readAddr = streamReadEn ? streamAddr : cmdAddr;
    assign readWord = storage[readAddr];

    // read buffer, reloads on every enabled edge
    always_ff @(posedge clk) begin
        if (clkEn) begin
            bufferData <= readWord;
        end
    end

    // an X address would corrupt an unknown location
    writeAddrKnown: assert property (@(posedge clk)
        (clkEn && writeEn) |-> !$isunknown(writeAddr));

endmodule

// ==== hw/flashStreamer.sv ====
module flashStreamer (
    input  logic clk,
    input  logic rstN,
    input  logic clkEn,
    input  logic startFire,
    input  flashIoPkg::decodedCmdT decoded,
    input  logic [flashIoPkg::memDataBits-1:0] bufferData,
    output logic readEn,
    output logic [flashIoPkg::memAddrBits-1:0] readAddr,
    output flashIoPkg::streamOutT streamOut,
    output logic streamBusy
);
    import flashIoPkg::*;

    logic [memAddrBits-1:0] addrCnt;
    logic [memAddrBits-1:0] remaining;
    logic [memAddrBits-1:0] addrDelay;
    logic validDelay;

    // busy while words are left to issue
    assign streamBusy = (remaining != '0);

    // one address out per busy cycle
    assign readEn = streamBusy;
    assign readAddr = addrCnt;

    // address and word counters
    // the address wraps at the top of memory on its own
    always_ff @(posedge clk) begin
        if (!rstN) begin
            addrCnt <= '0;
            remaining <= '0;
        end else if (clkEn) begin
            if (startFire) begin
                addrCnt <= decoded.addr;
                remaining <= decoded.count;
            end else if (streamBusy) begin
                addrCnt <= addrCnt + 1'b1;
                remaining <= remaining - 1'b1;
            end
        end
    end

    // issued flag follows the address by one stage
    // lines up with the word landing in the read buffer
    always_ff @(posedge clk) begin
        if (!rstN) begin
            validDelay <= 1'b0;
        end else if (clkEn) begin
            validDelay <= streamBusy;
        end
    end

    // address of the word now in the buffer
    always_ff @(posedge clk) begin
        if (clkEn) begin
            addrDelay <= addrCnt;
        end
    end

    // data comes straight from the read buffer
    assign streamOut.valid = validDelay;
    assign streamOut.addr = addrDelay;
    assign streamOut.data = bufferData;

    // decoder must hold off a new start during a stream
    noStartWhileBusy: assert property (@(posedge clk) disable iff (!rstN)
        startFire |-> !streamBusy);

    // a valid word without busy is the last one, nothing follows it
    validOnlyWhileBusy: assert property (@(posedge clk) disable iff (!rstN)
        (clkEn && streamOut.valid && !streamBusy) |=> !streamOut.valid);

endmodule

// ==== hw/ioCommandDecode.sv ====
module ioCommandDecode (
    input  logic clk,
    input  logic rstN,
    input  logic clkEn,
    input  logic ioOutAck,
    input  flashIoPkg::ioOutCmdT ioOutCmd,
    input  logic responsePending,
    input  logic streamBusy,
    output logic ioOutReq,
    output logic storeFire,
    output logic loadFire,
    output logic startFire,
    output logic statusFire,
    output flashIoPkg::decodedCmdT decoded
);
    import flashIoPkg::*;

    logic portReady;
    logic isCtrl;
    logic wantsResp;
    logic blocked;
    logic accept;

    // port stays closed until the first enabled edge out of reset
    always_ff @(posedge clk) begin
        if (!rstN) begin
            portReady <= 1'b0;
        end else if (clkEn) begin
            portReady <= 1'b1;
        end
    end

    // bit 31 is the same in both views
    assign isCtrl = ioOutCmd.word.mem.ctrl;
    assign wantsResp = ioOutCmd.responseRequested;

    // pick the view by the ctrl flag
    always_comb begin
        decoded.destReg = ioOutCmd.destReg;
        if (isCtrl) begin
            decoded.kind = wantsResp ? statusLoad : streamStart;
            decoded.addr = ioOutCmd.word.ctrl.startAddr;
            decoded.count = ioOutCmd.word.ctrl.count;
            decoded.data = '0;
        end else begin
            decoded.kind = wantsResp ? memLoad : memStore;
            decoded.addr = ioOutCmd.word.mem.addr;
            decoded.data = ioOutCmd.word.mem.data;
            decoded.count = '0;
        end
    end

    // any response waits for the pending one to drain
    // memory loads and starts also wait while the flasher owns the read port
    // status loads may go through during a stream
    assign blocked = (wantsResp && responsePending)
                   || (streamBusy && (decoded.kind == memLoad || decoded.kind == streamStart));

    assign ioOutReq = clkEn && portReady && !blocked;
    assign accept = ioOutReq && ioOutAck;

    // exactly one strobe per accepted command
    assign storeFire = accept && (decoded.kind == memStore);
    assign loadFire = accept && (decoded.kind == memLoad);
    assign startFire = accept && (decoded.kind == streamStart);
    assign statusFire = accept && (decoded.kind == statusLoad);

    // a command taken off the bus must be fully driven
    cmdKnown: assert property (@(posedge clk) disable iff (!rstN)
        accept |-> !$isunknown(ioOutCmd));

endmodule

// ==== hw/ioResponse.sv ====
module ioResponse (
    input  logic clk,
    input  logic rstN,
    input  logic clkEn,
    input  logic loadFire,
    input  logic statusFire,
    input  flashIoPkg::decodedCmdT decoded,
    input  logic [flashIoPkg::memDataBits-1:0] bufferData,
    input  logic streamBusy,
    input  logic ioInReq,
    output logic ioInAck,
    output flashIoPkg::ioResponseT ioInResp,
    output logic responsePending
);
    import flashIoPkg::*;

    logic pending;
    logic isStatus;
    logic busyHeld;
    logic firstCycle;
    logic [3:0] destRegHeld;
    logic [memDataBits-1:0] heldData;
    logic [memDataBits-1:0] loadData;
    logic consume;

    // response taken by the processor
    assign consume = clkEn && pending && ioInReq;

    // pending flag and response source
    always_ff @(posedge clk) begin
        if (!rstN) begin
            pending <= 1'b0;
            isStatus <= 1'b0;
            firstCycle <= 1'b0;
        end else if (clkEn) begin
            if (loadFire || statusFire) begin
                pending <= 1'b1;
                isStatus <= statusFire;
                firstCycle <= loadFire;
            end else begin
                firstCycle <= 1'b0;
                if (consume) begin
                    pending <= 1'b0;
                end
            end
        end
    end

    // payload captured with the fire strobe
    // busy is sampled at the accepting edge
    always_ff @(posedge clk) begin
        if (clkEn && (loadFire || statusFire)) begin
            destRegHeld <= decoded.destReg;
            busyHeld <= streamBusy;
        end
    end

    // buffer moves on after one cycle, so keep a copy
    always_ff @(posedge clk) begin
        if (clkEn && firstCycle) begin
            heldData <= bufferData;
        end
    end

    // first cycle reads the buffer directly
    assign loadData = firstCycle ? bufferData : heldData;

    assign ioInResp.regResponse = pending;
    assign ioInResp.memResponse = 1'b0;
    assign ioInResp.destReg = destRegHeld;
    assign ioInResp.data = isStatus ? {31'b0, busyHeld} : {16'b0, loadData};

    assign ioInAck = pending;
    assign responsePending = pending;

    // request gating upstream keeps a second response out
    noFireWhilePending: assert property (@(posedge clk) disable iff (!rstN)
        (loadFire || statusFire) |-> !responsePending);

endmodule

// ==== hw/memoryFlasher.sv ====
module memoryFlasher (
    input  logic clk,
    input  logic rstN,
    input  logic clkEn,
    input  logic ioOutAck,
    input  flashIoPkg::ioOutCmdT ioOutCmd,
    output logic ioOutReq,
    input  logic ioInReq,
    output logic ioInAck,
    output flashIoPkg::ioResponseT ioInResp,
    output flashIoPkg::streamOutT streamOut,
    output logic streamBusy
);
    import flashIoPkg::*;

    decodedCmdT decoded;
    logic storeFire;
    logic loadFire;
    logic startFire;
    logic statusFire;
    logic responsePending;
    logic readEn;
    logic [memAddrBits-1:0] readAddr;
    logic [memDataBits-1:0] bufferData;

    // decode stage, owns the outgoing request
    ioCommandDecode decode (
        .clk(clk),
        .rstN(rstN),
        .clkEn(clkEn),
        .ioOutAck(ioOutAck),
        .ioOutCmd(ioOutCmd),
        .responsePending(responsePending),
        .streamBusy(streamBusy),
        .ioOutReq(ioOutReq),
        .storeFire(storeFire),
        .loadFire(loadFire),
        .startFire(startFire),
        .statusFire(statusFire),
        .decoded(decoded)
    );

    // storage, shared read port
    flashMemory memory (
        .clk(clk),
        .clkEn(clkEn),
        .writeEn(storeFire),
        .writeAddr(decoded.addr),
        .writeData(decoded.data),
        .streamReadEn(readEn),
        .streamAddr(readAddr),
        .cmdAddr(decoded.addr),
        .bufferData(bufferData)
    );

    // second executor, sequential readout
    flashStreamer streamer (
        .clk(clk),
        .rstN(rstN),
        .clkEn(clkEn),
        .startFire(startFire),
        .decoded(decoded),
        .bufferData(bufferData),
        .readEn(readEn),
        .readAddr(readAddr),
        .streamOut(streamOut),
        .streamBusy(streamBusy)
    );

    // result stage, drives the incoming port
    ioResponse response (
        .clk(clk),
        .rstN(rstN),
        .clkEn(clkEn),
        .loadFire(loadFire),
        .statusFire(statusFire),
        .decoded(decoded),
        .bufferData(bufferData),
        .streamBusy(streamBusy),
        .ioInReq(ioInReq),
        .ioInAck(ioInAck),
        .ioInResp(ioInResp),
        .responsePending(responsePending)
    );

endmodule

// ==== memoryFlasher.f ====
hw/flashIoPkg.sv
hw/ioCommandDecode.sv
hw/flashMemory.sv
hw/flashStreamer.sv
hw/ioResponse.sv
hw/memoryFlasher.sv
verification/memoryFlasherTb.sv

// ==== runSim.sh ====
#!/bin/sh
# build and run the memoryFlasher testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! rm -rf obj_dir sim.log; then
    echo "could not clean the build directory"
    exit 1
fi

if ! verilator --binary --timing --assert --top-module memoryFlasherTb -f memoryFlasher.f; then
    echo "build failed"
    exit 1
fi

if ! ./obj_dir/VmemoryFlasherTb > sim.log 2>&1; then
    echo "simulation exited with an error, see sim.log"
    exit 1
fi

if grep -q "ALL TESTS PASSED" sim.log; then
    echo "simulation passed"
    exit 0
fi

echo "simulation failed, see sim.log"
exit 1

// ==== verification/memoryFlasherTb.sv ====
module memoryFlasherTb;
    import flashIoPkg::*;

    localparam int waitLimit = 200;

    typedef enum logic [2:0] {
        opStore,
        opLoad,
        opLoadHold,
        opStatus,
        opStart,
        opWaitStream,
        opStall
    } opKindT;

    // one table row
    // count is the stream length, or the clkEn low time for loads and stalls
    typedef struct packed {
        opKindT kind;
        logic [memAddrBits-1:0] addr;
        logic [memDataBits-1:0] data;
        logic [memAddrBits-1:0] count;
        logic [31:0] expected;
    } opEntryT;

    logic clk;
    logic rstN;
    logic clkEn;
    logic ioOutAck;
    ioOutCmdT ioOutCmd;
    logic ioOutReq;
    logic ioInReq;
    logic ioInAck;
    ioResponseT ioInResp;
    streamOutT streamOut;
    logic streamBusy;

    logic [31:0] lfsrState;
    logic [memDataBits-1:0] shadow [memDepth];
    opEntryT ops [$];

    // stream collector state
    logic edgeEnabled;
    logic [memAddrBits-1:0] streamAddr;
    int streamGot;
    int streamTotal;
    streamOutT lastWord;
    streamOutT expWord;

    memoryFlasher dut (.*);

    always #5 clk = ~clk;

    task automatic failRun(input string line);
        $display("%s", line);
        $display("SOME TESTS FAILED");
        $fatal(1, "stopped at first failure");
    endtask

    task automatic checkLevel(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            failRun($sformatf("ERROR %s got %h expected %h", name, got, exp));
        end
    endtask

    task automatic checkResponse(input string name, input ioResponseT got, input ioResponseT exp);
        if (got !== exp) begin
            failRun($sformatf("ERROR %s got %h expected %h", name, got, exp));
        end
    endtask

    task automatic checkStreamWord(input string name, input streamOutT got, input streamOutT exp);
        if (got !== exp) begin
            failRun($sformatf("ERROR %s got %h expected %h", name, got, exp));
        end
    endtask

    // galois lfsr with taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] stepLfsr(input logic [31:0] state);
        if (state[0]) begin
            return (state >> 1) ^ 32'h8020_0003;
        end
        return state >> 1;
    endfunction

    // one lfsr step per bit taken
    function automatic logic [31:0] nextRandomBits(input int count);
        logic [31:0] bits;
        int k;
        bits = '0;
        for (k = 0; k < count; k++) begin
            bits = {bits[30:0], lfsrState[0]};
            lfsrState = stepLfsr(lfsrState);
        end
        return bits;
    endfunction

    function automatic ioOutCmdT memCmd(input logic resp, input logic [3:0] dest,
                                        input logic [memAddrBits-1:0] addr,
                                        input logic [memDataBits-1:0] data);
        ioOutCmdT cmd;
        cmd.responseRequested = resp;
        cmd.destReg = dest;
        cmd.word.mem.ctrl = 1'b0;
        cmd.word.mem.reserved = '0;
        cmd.word.mem.addr = addr;
        cmd.word.mem.data = data;
        return cmd;
    endfunction

    function automatic ioOutCmdT ctrlCmd(input logic resp, input logic [3:0] dest,
                                         input logic [memAddrBits-1:0] start,
                                         input logic [memAddrBits-1:0] count);
        ioOutCmdT cmd;
        cmd.responseRequested = resp;
        cmd.destReg = dest;
        cmd.word.ctrl.ctrl = 1'b1;
        cmd.word.ctrl.reserved = '0;
        cmd.word.ctrl.startAddr = start;
        cmd.word.ctrl.pad = '0;
        cmd.word.ctrl.count = count;
        return cmd;
    endfunction

    task automatic addOp(input opKindT kind, input logic [memAddrBits-1:0] addr,
                         input logic [memDataBits-1:0] data, input logic [memAddrBits-1:0] count,
                         input logic [31:0] expected);
        ops.push_back(opEntryT'{kind, addr, data, count, expected});
    endtask

    // tasks below start on a falling edge and return on one
    // inputs change right at the edge and outputs are sampled 1 unit later
    task automatic issueCommand(input ioOutCmdT cmd);
        int waited;
        waited = 0;
        ioOutCmd = cmd;
        ioOutAck = 1'b1;
        #1;
        while (!ioOutReq) begin
            waited++;
            if (waited > waitLimit) begin
                failRun("timeout, the DUT never raised ioOutReq for a command");
            end
            @(negedge clk);
            #1;
        end
        // accepted on the rising edge in between
        @(negedge clk);
        ioOutAck = 1'b0;
    endtask

    task automatic takeResponse(input logic [3:0] dest, input logic [31:0] expData,
                                input int stallCycles, input logic holdStore,
                                input logic [memAddrBits-1:0] otherAddr);
        ioResponseT exp;
        logic [memDataBits-1:0] storeData;
        int waited;
        int holdCycles;
        int c;
        exp.regResponse = 1'b1;
        exp.memResponse = 1'b0;
        exp.destReg = dest;
        exp.data = expData;
        waited = 0;
        holdCycles = 1 + int'(nextRandomBits(3));
        ioInReq = 1'b0;
        #1;
        while (!ioInAck) begin
            waited++;
            if (waited > waitLimit) begin
                failRun("timeout, no response arrived on ioInAck");
            end
            @(negedge clk);
            #1;
        end
        checkResponse("ioInResp", ioInResp, exp);
        // under back-pressure the response holds and further loads are refused
        for (c = 0; c < holdCycles; c++) begin
            @(negedge clk);
            ioOutCmd = memCmd(1'b1, 4'h0, otherAddr, 16'h0);
            #1;
            checkLevel("ioOutReq", ioOutReq, 1'b0);
            checkResponse("ioInResp", ioInResp, exp);
        end
        // a store still goes through while the response waits
        if (holdStore) begin
            storeData = 16'(nextRandomBits(16));
            @(negedge clk);
            issueCommand(memCmd(1'b0, 4'h0, otherAddr, storeData));
            shadow[otherAddr] = storeData;
            #1;
            checkResponse("ioInResp", ioInResp, exp);
        end
        @(negedge clk);
        // with the clock frozen nothing is consumed even with ioInReq high
        if (stallCycles > 0) begin
            clkEn = 1'b0;
            ioInReq = 1'b1;
            for (c = 0; c < stallCycles; c++) begin
                #1;
                checkLevel("ioOutReq", ioOutReq, 1'b0);
                checkLevel("ioInAck", ioInAck, 1'b1);
                checkResponse("ioInResp", ioInResp, exp);
                @(negedge clk);
            end
            clkEn = 1'b1;
        end
        ioInReq = 1'b1;
        #1;
        checkResponse("ioInResp", ioInResp, exp);
        @(negedge clk);
        ioInReq = 1'b0;
        #1;
        checkLevel("ioInAck", ioInAck, 1'b0);
        @(negedge clk);
    endtask

    task automatic startStream(input logic [memAddrBits-1:0] start,
                               input logic [memAddrBits-1:0] count, input logic [3:0] dest);
        streamAddr = start;
        streamGot = 0;
        streamTotal = int'(count);
        issueCommand(ctrlCmd(1'b0, dest, start, count));
        #1;
        checkLevel("streamBusy", streamBusy, count != '0);
        @(negedge clk);
    endtask

    task automatic waitStreamDone();
        int waited;
        waited = 0;
        #1;
        while (streamGot < streamTotal) begin
            waited++;
            if (waited > waitLimit) begin
                failRun("timeout, the stream delivered too few words");
            end
            @(negedge clk);
            #1;
        end
        checkLevel("streamBusy", streamBusy, 1'b0);
        @(negedge clk);
    endtask

    // clkEn low in the middle of a stream with a store offered that must not land
    task automatic stallClock(input logic [memAddrBits-1:0] addr,
                              input logic [memDataBits-1:0] data, input int cycles);
        int waited;
        int c;
        waited = 0;
        #1;
        while (!streamOut.valid) begin
            waited++;
            if (waited > waitLimit) begin
                failRun("timeout, streamOut.valid never rose before the stall");
            end
            @(negedge clk);
            #1;
        end
        @(negedge clk);
        clkEn = 1'b0;
        ioOutCmd = memCmd(1'b0, 4'h0, addr, data);
        ioOutAck = 1'b1;
        for (c = 0; c < cycles; c++) begin
            #1;
            checkLevel("ioOutReq", ioOutReq, 1'b0);
            @(negedge clk);
        end
        clkEn = 1'b1;
        ioOutAck = 1'b0;
    endtask

    always @(posedge clk) begin
        edgeEnabled <= clkEn;
    end

    // stream collector takes one word per enabled edge
    // a disabled edge must leave the last word in place
    always @(negedge clk) begin
        if (streamOut.valid) begin
            if (!edgeEnabled) begin
                checkStreamWord("streamOut", streamOut, lastWord);
            end else if (streamGot >= streamTotal) begin
                failRun("a stream word arrived when none was expected");
            end else begin
                expWord.valid = 1'b1;
                expWord.addr = streamAddr;
                expWord.data = shadow[streamAddr];
                checkStreamWord("streamOut", streamOut, expWord);
                // busy drops together with the last word
                checkLevel("streamBusy", streamBusy, streamGot + 1 < streamTotal);
                lastWord = streamOut;
                streamAddr = streamAddr + 11'd1;
                streamGot = streamGot + 1;
            end
        end
    end

    initial begin
        opEntryT op;
        logic [3:0] dest;
        logic [memDataBits-1:0] data;
        int a;
        int i;
        clk = 1'b0;
        rstN = 1'b0;
        clkEn = 1'b1;
        ioOutAck = 1'b0;
        ioOutCmd = '0;
        ioInReq = 1'b0;
        lfsrState = 32'hbb2e_60aa;
        streamAddr = '0;
        streamGot = 0;
        streamTotal = 0;
        lastWord = '0;
        expWord = '0;

        // store then read back at once
        addOp(opStore, 11'h005, 16'h0, 11'd0, 32'h0);
        addOp(opLoad, 11'h005, 16'h0, 11'd0, 32'h0);
        // words around the top of memory for the wrapping stream
        for (a = 0; a < 7; a++) begin
            addOp(opStore, 11'h7fc + 11'(a), 16'h0, 11'd0, 32'h0);
        end
        addOp(opLoad, 11'h7ff, 16'h0, 11'd0, 32'h0);
        addOp(opLoad, 11'h001, 16'h0, 11'd3, 32'h0);
        // held response with a store to the next address meanwhile
        addOp(opLoadHold, 11'h000, 16'h0, 11'd0, 32'h0);
        addOp(opLoad, 11'h001, 16'h0, 11'd0, 32'h0);
        addOp(opStatus, 11'h000, 16'h0, 11'd0, 32'h0);
        addOp(opStart, 11'h7fc, 16'h0, 11'd7, 32'h0);
        addOp(opStatus, 11'h000, 16'h0, 11'd0, 32'h1);
        addOp(opWaitStream, 11'h000, 16'h0, 11'd0, 32'h0);
        addOp(opStatus, 11'h000, 16'h0, 11'd0, 32'h0);
        for (a = 0; a < 8; a++) begin
            addOp(opStore, 11'h200 + 11'(a), 16'h0, 11'd0, 32'h0);
        end
        addOp(opStart, 11'h200, 16'h0, 11'd8, 32'h0);
        addOp(opStall, 11'h203, 16'hdead, 11'd4, 32'h0);
        addOp(opWaitStream, 11'h000, 16'h0, 11'd0, 32'h0);
        addOp(opLoad, 11'h203, 16'h0, 11'd0, 32'h0);
        // empty stream never goes busy
        addOp(opStart, 11'h200, 16'h0, 11'd0, 32'h0);
        addOp(opStatus, 11'h000, 16'h0, 11'd0, 32'h0);

        repeat (2) @(negedge clk);
        rstN = 1'b1;
        #1;
        checkLevel("ioOutReq", ioOutReq, 1'b0);
        checkLevel("ioInAck", ioInAck, 1'b0);
        checkLevel("streamOut.valid", streamOut.valid, 1'b0);
        checkLevel("streamBusy", streamBusy, 1'b0);
        @(negedge clk);

        for (i = 0; i < ops.size(); i++) begin
            op = ops[i];
            dest = 4'(i);
            case (op.kind)
                opStore: begin
                    data = 16'(nextRandomBits(16));
                    issueCommand(memCmd(1'b0, dest, op.addr, data));
                    shadow[op.addr] = data;
                end
                opLoad: begin
                    issueCommand(memCmd(1'b1, dest, op.addr, 16'h0));
                    takeResponse(dest, {16'h0, shadow[op.addr]}, int'(op.count), 1'b0, op.addr);
                end
                opLoadHold: begin
                    issueCommand(memCmd(1'b1, dest, op.addr, 16'h0));
                    takeResponse(dest, {16'h0, shadow[op.addr]}, 0, 1'b1, op.addr + 11'd1);
                end
                opStatus: begin
                    issueCommand(ctrlCmd(1'b1, dest, 11'h0, 11'h0));
                    takeResponse(dest, op.expected, 0, 1'b0, op.addr);
                end
                opStart: startStream(op.addr, op.count, dest);
                opWaitStream: waitStreamDone();
                opStall: stallClock(op.addr, op.data, int'(op.count));
                default: failRun("unknown operation in the stimulus table");
            endcase
        end

        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule
